//--- filelist.f
+incdir+hdl
+incdir+sim
hdl/noc_pkg.sv
hdl/noc_in_fifo.sv
hdl/noc_route_xy.sv
hdl/noc_switch_alloc.sv
hdl/noc_chan_router.sv
hdl/noc_nw_router.sv
sim/noc_nw_router_tb.sv

//--- hdl/noc_chan_router.sv
/*
  Five-port XY router for one flit type
  flit_t must be a packed struct with a field hdr of type noc_pkg::hdr_t
  Input FIFOs only, no output buffering; minimum latency is one cycle
*/
`default_nettype none

`include "noc_settings.svh"

module noc_chan_router #(
  parameter type         flit_t    = logic,
  parameter int unsigned FifoDepth = `NOC_FIFO_DEPTH
) (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,
  input  wire noc_pkg::coord_t             node_i,
  input  wire  [`NOC_NUM_PORTS-1:0]        in_valid_i,
  output logic [`NOC_NUM_PORTS-1:0]        in_ready_o,
  input  wire flit_t [`NOC_NUM_PORTS-1:0]  in_flit_i,
  output logic [`NOC_NUM_PORTS-1:0]        out_valid_o,
  input  wire  [`NOC_NUM_PORTS-1:0]        out_ready_i,
  output flit_t [`NOC_NUM_PORTS-1:0]       out_flit_o
);

  localparam int unsigned NumPorts = `NOC_NUM_PORTS;

  logic  [NumPorts-1:0]               head_valid;
  logic  [NumPorts-1:0]               head_pop;
  flit_t [NumPorts-1:0]               head_flit;
  // Route and request are [input][output], grant is [output][input]
  logic  [NumPorts-1:0][NumPorts-1:0] route;
  logic  [NumPorts-1:0][NumPorts-1:0] req;
  logic  [NumPorts-1:0][NumPorts-1:0] gnt;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_port
    noc_in_fifo #(
      .flit_t (flit_t),
      .Depth  (FifoDepth)
    ) fifo_inst (
      .clk_i,
      .reset_i,
      .valid_i (in_valid_i[i]),
      .ready_o (in_ready_o[i]),
      .flit_i  (in_flit_i[i]),
      .valid_o (head_valid[i]),
      .ready_i (head_pop[i]),
      .flit_o  (head_flit[i])
    );

    noc_route_xy route_inst (
      .dst_i  (head_flit[i].hdr.dst),
      .node_i (node_i),
      .out_o  (route[i])
    );

    // An empty FIFO shows a stale head, so its route is dropped
    assign req[i] = head_valid[i] ? route[i] : '0;
  end

  noc_switch_alloc alloc_inst (
    .clk_i,
    .reset_i,
    .req_i       (req),
    .out_ready_i (out_ready_i),
    .gnt_o       (gnt),
    .out_valid_o (out_valid_o)
  );

  // Crossbar, the granted head drives each output
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      out_flit_o[o] = '0;
      for (int i = 0; i < NumPorts; i++) begin
        if (gnt[o][i]) begin
          out_flit_o[o] = head_flit[i];
        end
      end
    end
  end

  // Each head has one route, so at most one output pops it
  always_comb begin
    head_pop = '0;
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        if (gnt[o][i] && out_ready_i[o]) begin
          head_pop[i] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/noc_in_fifo.sv
/*
  Input FIFO with valid/ready on both sides and a combinational head
  A flit pushed at one edge is at the head from the next cycle on
  ready_o only reflects full, so a full FIFO takes no push while popping
*/
`default_nettype none

`include "noc_settings.svh"

module noc_in_fifo #(
  parameter type         flit_t = logic,
  parameter int unsigned Depth  = `NOC_FIFO_DEPTH
) (
  input  wire logic  clk_i,
  input  wire logic  reset_i,
  input  wire logic  valid_i,
  output logic       ready_o,
  input  wire flit_t flit_i,
  output logic       valid_o,
  input  wire logic  ready_i,
  output flit_t      flit_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  flit_t           mem_q [Depth];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ready_o = (count_q != CntW'(Depth));
  assign valid_o = (count_q != '0);
  assign flit_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/noc_nw_router.sv
/*
  Mesh node with narrow request, narrow response and wide networks
  Each network routes XY on node_i independently of the others
  Links follow the usual valid/ready rule, ready comes back in the other struct
*/
`default_nettype none

`include "noc_settings.svh"

module noc_nw_router (
  input  wire logic                                   clk_i,
  input  wire logic                                   reset_i,
  input  wire noc_pkg::coord_t                        node_i,
  input  wire noc_pkg::req_link_t  [`NOC_NUM_PORTS-1:0] req_i,
  output noc_pkg::req_link_t       [`NOC_NUM_PORTS-1:0] req_o,
  input  wire noc_pkg::rsp_link_t  [`NOC_NUM_PORTS-1:0] rsp_i,
  output noc_pkg::rsp_link_t       [`NOC_NUM_PORTS-1:0] rsp_o,
  input  wire noc_pkg::wide_link_t [`NOC_NUM_PORTS-1:0] wide_i,
  output noc_pkg::wide_link_t      [`NOC_NUM_PORTS-1:0] wide_o
);

  localparam int unsigned NumPorts = `NOC_NUM_PORTS;

  logic [NumPorts-1:0] req_in_valid, req_in_ready, req_out_valid, req_out_ready;
  logic [NumPorts-1:0] rsp_in_valid, rsp_in_ready, rsp_out_valid, rsp_out_ready;
  logic [NumPorts-1:0] wide_in_valid, wide_in_ready, wide_out_valid, wide_out_ready;
  noc_pkg::req_flit_t  [NumPorts-1:0] req_in_flit, req_out_flit;
  noc_pkg::rsp_flit_t  [NumPorts-1:0] rsp_in_flit, rsp_out_flit;
  noc_pkg::wide_flit_t [NumPorts-1:0] wide_in_flit, wide_out_flit;

  // Split links into the forward half and the returning ready
  for (genvar i = 0; i < NumPorts; i++) begin : gen_link
    assign req_in_valid[i]   = req_i[i].valid;
    assign req_in_flit[i]    = req_i[i].flit;
    assign req_out_ready[i]  = req_i[i].ready;
    assign req_o[i].valid    = req_out_valid[i];
    assign req_o[i].ready    = req_in_ready[i];
    assign req_o[i].flit     = req_out_flit[i];

    assign rsp_in_valid[i]   = rsp_i[i].valid;
    assign rsp_in_flit[i]    = rsp_i[i].flit;
    assign rsp_out_ready[i]  = rsp_i[i].ready;
    assign rsp_o[i].valid    = rsp_out_valid[i];
    assign rsp_o[i].ready    = rsp_in_ready[i];
    assign rsp_o[i].flit     = rsp_out_flit[i];

    assign wide_in_valid[i]  = wide_i[i].valid;
    assign wide_in_flit[i]   = wide_i[i].flit;
    assign wide_out_ready[i] = wide_i[i].ready;
    assign wide_o[i].valid   = wide_out_valid[i];
    assign wide_o[i].ready   = wide_in_ready[i];
    assign wide_o[i].flit    = wide_out_flit[i];
  end

  noc_chan_router #(.flit_t(noc_pkg::req_flit_t)) req_router_inst (
    .clk_i,
    .reset_i,
    .node_i,
    .in_valid_i  (req_in_valid),
    .in_ready_o  (req_in_ready),
    .in_flit_i   (req_in_flit),
    .out_valid_o (req_out_valid),
    .out_ready_i (req_out_ready),
    .out_flit_o  (req_out_flit)
  );

  noc_chan_router #(.flit_t(noc_pkg::rsp_flit_t)) rsp_router_inst (
    .clk_i,
    .reset_i,
    .node_i,
    .in_valid_i  (rsp_in_valid),
    .in_ready_o  (rsp_in_ready),
    .in_flit_i   (rsp_in_flit),
    .out_valid_o (rsp_out_valid),
    .out_ready_i (rsp_out_ready),
    .out_flit_o  (rsp_out_flit)
  );

  noc_chan_router #(.flit_t(noc_pkg::wide_flit_t)) wide_router_inst (
    .clk_i,
    .reset_i,
    .node_i,
    .in_valid_i  (wide_in_valid),
    .in_ready_o  (wide_in_ready),
    .in_flit_i   (wide_in_flit),
    .out_valid_o (wide_out_valid),
    .out_ready_i (wide_out_ready),
    .out_flit_o  (wide_out_flit)
  );

endmodule

`default_nettype wire

//--- hdl/noc_pkg.sv
/*
  Flit and link types for the narrow request, narrow response and wide networks
  Every flit is a single-flit packet carrying its own routing header
  A link struct carries valid and flit of one direction plus the ready of the other
*/
`default_nettype none

`include "noc_settings.svh"

package noc_pkg;

  // Port index used by every network and by the route computation
  typedef enum logic [2:0] {
    PORT_N = 3'd0,
    PORT_E = 3'd1,
    PORT_S = 3'd2,
    PORT_W = 3'd3,
    PORT_L = 3'd4
  } port_e;

  localparam int unsigned AddrW = 32;

  typedef struct packed {
    logic [`NOC_COORD_W-1:0] x;
    logic [`NOC_COORD_W-1:0] y;
  } coord_t;

  typedef struct packed {
    coord_t     dst;
    coord_t     src;
    logic [7:0] tag;
  } hdr_t;

  typedef struct packed {
    hdr_t                     hdr;
    logic                     write;
    logic [AddrW-1:0]         addr;
    logic [`NOC_NARROW_DW-1:0] data;
  } req_flit_t;

  // One response word, read as a write ack (b) or as read data (r)
  typedef union packed {
    struct packed {
      logic [7:0]                id;
      logic [1:0]                resp;
      // Pads the b view up to the width of the r view
      logic [`NOC_NARROW_DW-3:0] rsvd;
    } b;
    struct packed {
      logic [7:0]                id;
      logic [`NOC_NARROW_DW-1:0] data;
    } r;
  } rsp_payload_u;

  typedef struct packed {
    hdr_t         hdr;
    logic         is_r;
    rsp_payload_u payload;
  } rsp_flit_t;

  typedef struct packed {
    hdr_t                    hdr;
    logic [`NOC_WIDE_DW-1:0] data;
  } wide_flit_t;

  typedef struct packed {
    logic      valid;
    logic      ready;
    req_flit_t flit;
  } req_link_t;

  typedef struct packed {
    logic      valid;
    logic      ready;
    rsp_flit_t flit;
  } rsp_link_t;

  typedef struct packed {
    logic       valid;
    logic       ready;
    wide_flit_t flit;
  } wide_link_t;

endpackage

`default_nettype wire

//--- hdl/noc_route_xy.sv
/*
  Dimension-ordered XY route computation, purely combinational
  X is resolved first, then Y; a flit for this node leaves on Local
  North is the direction of increasing Y
*/
`default_nettype none

`include "noc_settings.svh"

module noc_route_xy (
  input  wire noc_pkg::coord_t      dst_i,
  input  wire noc_pkg::coord_t      node_i,
  output logic [`NOC_NUM_PORTS-1:0] out_o
);

  always_comb begin
    out_o = '0;
    if (dst_i.x > node_i.x) begin
      out_o[noc_pkg::PORT_E] = 1'b1;
    end else if (dst_i.x < node_i.x) begin
      out_o[noc_pkg::PORT_W] = 1'b1;
    end else if (dst_i.y > node_i.y) begin
      // Column reached, now move along Y
      out_o[noc_pkg::PORT_N] = 1'b1;
    end else if (dst_i.y < node_i.y) begin
      out_o[noc_pkg::PORT_S] = 1'b1;
    end else begin
      out_o[noc_pkg::PORT_L] = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/noc_settings.svh
/*
  Global sizes shared by the package and the router RTL
  Coordinates are per axis, so the mesh is 2**NOC_COORD_W nodes on a side
  Data widths set the flit layouts in noc_pkg; the testbench relies on them
*/

`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Width of one mesh coordinate, 4x4 mesh
`define NOC_COORD_W 2

// Ports per network in the order N, E, S, W, L
`define NOC_NUM_PORTS 5

// Payload width of the narrow request and response networks
`define NOC_NARROW_DW 32

// Payload width of the wide data network
`define NOC_WIDE_DW 128

// Default input FIFO depth, must be at least 1
`define NOC_FIFO_DEPTH 2

`endif

//--- hdl/noc_switch_alloc.sv
/*
  Round-robin switch allocator, one arbiter per output
  Requests are [input][output] and must already be masked by FIFO valid
  A stalled output keeps its grant until the flit is taken
*/
`default_nettype none

`include "noc_settings.svh"

module noc_switch_alloc (
  input  wire logic                                      clk_i,
  input  wire logic                                      reset_i,
  // Request matrix, [input][output]
  input  wire  [`NOC_NUM_PORTS-1:0][`NOC_NUM_PORTS-1:0]  req_i,
  input  wire  [`NOC_NUM_PORTS-1:0]                      out_ready_i,
  // Grant matrix, [output][input], at most one bit per output
  output logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_PORTS-1:0]  gnt_o,
  output logic [`NOC_NUM_PORTS-1:0]                      out_valid_o
);

  localparam int unsigned NumPorts = `NOC_NUM_PORTS;
  localparam int unsigned IdxW     = $clog2(NumPorts);

  logic [NumPorts-1:0][NumPorts-1:0] req_by_out;
  logic [NumPorts-1:0][NumPorts-1:0] hold_q;
  logic [NumPorts-1:0]               lock_q;
  logic [NumPorts-1:0][IdxW-1:0]     ptr_q;
  logic [NumPorts-1:0][IdxW-1:0]     ptr_next;

  // One-hot pick of the first requester at or after ptr
  function automatic logic [NumPorts-1:0] rr_arb(
    input logic [NumPorts-1:0] req,
    input logic [IdxW-1:0]     ptr
  );
    logic [NumPorts-1:0] pick;
    int unsigned         idx;
    pick = '0;
    // Scan backwards so the requester closest to ptr is written last
    for (int k = NumPorts - 1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % NumPorts;
      if (req[idx]) begin
        pick      = '0;
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        req_by_out[o][i] = req_i[i][o];
      end
    end
  end

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      gnt_o[o]       = lock_q[o] ? hold_q[o] : rr_arb(req_by_out[o], ptr_q[o]);
      out_valid_o[o] = |gnt_o[o];
    end
  end

  // Pointer moves to the input just after the winner
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      ptr_next[o] = ptr_q[o];
      for (int i = 0; i < NumPorts; i++) begin
        if (gnt_o[o][i]) begin
          ptr_next[o] = (i == NumPorts - 1) ? '0 : IdxW'(i + 1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q  <= '0;
      lock_q <= '0;
    end else begin
      for (int o = 0; o < NumPorts; o++) begin
        lock_q[o] <= out_valid_o[o] & ~out_ready_i[o];
        if (out_valid_o[o] && out_ready_i[o]) begin
          ptr_q[o] <= ptr_next[o];
        end
      end
    end
  end

  // Saved winner, only looked at while the output is locked
  always_ff @(posedge clk_i) begin
    hold_q <= gnt_o;
  end

endmodule

`default_nettype wire

//--- sim/noc_tb_model.svh
/*
  Reference model, included inside the testbench module after noc_settings.svh
  Expected flits wait in one queue per network, input and output
  Relies on report_failure from the including module
*/
`ifndef NOC_TB_MODEL_SVH
`define NOC_TB_MODEL_SVH

  // Indexed [input][output], order per pair must match the DUT
  noc_pkg::req_flit_t  req_q  [`NOC_NUM_PORTS][`NOC_NUM_PORTS][$];
  noc_pkg::rsp_flit_t  rsp_q  [`NOC_NUM_PORTS][`NOC_NUM_PORTS][$];
  noc_pkg::wide_flit_t wide_q [`NOC_NUM_PORTS][`NOC_NUM_PORTS][$];

  // X first, then Y with north as the larger Y
  function automatic int xy_port(input noc_pkg::coord_t dst, input noc_pkg::coord_t node);
    if (dst.x != node.x) begin
      return (dst.x > node.x) ? int'(noc_pkg::PORT_E) : int'(noc_pkg::PORT_W);
    end
    if (dst.y != node.y) begin
      return (dst.y > node.y) ? int'(noc_pkg::PORT_N) : int'(noc_pkg::PORT_S);
    end
    return int'(noc_pkg::PORT_L);
  endfunction

  function automatic int pending();
    int n = 0;
    for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
      for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
        n += req_q[i][o].size() + rsp_q[i][o].size() + wide_q[i][o].size();
      end
    end
    return n;
  endfunction

  task automatic check_req(input string name, input noc_pkg::req_flit_t exp,
                           input noc_pkg::req_flit_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_rsp(input string name, input noc_pkg::rsp_flit_t exp,
                           input noc_pkg::rsp_flit_t act);
    bit same;
    same = (act.hdr === exp.hdr) && (act.is_r === exp.is_r);
    // is_r picks the view of the payload word
    if (exp.is_r) begin
      same = same && (act.payload.r.id === exp.payload.r.id) &&
             (act.payload.r.data === exp.payload.r.data);
    end else begin
      same = same && (act.payload.b.id === exp.payload.b.id) &&
             (act.payload.b.resp === exp.payload.b.resp) &&
             (act.payload.b.rsvd === exp.payload.b.rsvd);
    end
    if (!same) begin
      report_failure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_wide(input string name, input noc_pkg::wide_flit_t exp,
                            input noc_pkg::wide_flit_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

`endif

//--- sim/noc_nw_router_tb.sv
/*
  Self-checking testbench for noc_nw_router placed at node (1,2)
  Seeded random traffic and output ready on all three networks
  Stops at the first mismatch and passes once every expected flit has arrived
*/
`default_nettype none

`include "noc_settings.svh"

module noc_nw_router_tb;

  localparam int NumPorts   = `NOC_NUM_PORTS;
  localparam int FlitsPerIn = 60;
  localparam int CycleLimit = 40 * 3 * NumPorts * FlitsPerIn + 200;
  localparam int CoordW     = $bits(noc_pkg::coord_t);
  localparam int ReqW       = $bits(noc_pkg::req_flit_t);
  localparam int RspW       = $bits(noc_pkg::rsp_flit_t);
  localparam int WideW      = $bits(noc_pkg::wide_flit_t);

  logic            clk_i;
  logic            reset_i;
  noc_pkg::coord_t node_i;
  noc_pkg::req_link_t  [NumPorts-1:0] req_i, req_o, req_i_prev, req_o_prev;
  noc_pkg::rsp_link_t  [NumPorts-1:0] rsp_i, rsp_o, rsp_i_prev, rsp_o_prev;
  noc_pkg::wide_link_t [NumPorts-1:0] wide_i, wide_o, wide_i_prev, wide_o_prev;
  // Input flits taken at the coming edge, rows are req, rsp, wide
  logic [2:0][NumPorts-1:0] taken;
  int                       sent [3][NumPorts];
  int                       cycle_cnt;
  integer                   seed = 32'h3201_2f99;

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  `include "noc_tb_model.svh"

  noc_nw_router noc_nw_router_inst (
    .clk_i,
    .reset_i,
    .node_i,
    .req_i,
    .req_o,
    .rsp_i,
    .rsp_o,
    .wide_i,
    .wide_o
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > CycleLimit) begin
      report_failure($sformatf("Timeout after %0d cycles with flits still missing", cycle_cnt));
    end
  end

  function automatic bit chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic logic [159:0] rand_bits();
    return {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // A taken or idle input may offer its next flit, src is the input index
  task automatic drive_inputs();
    for (int i = 0; i < NumPorts; i++) begin
      if (!req_i[i].valid || taken[0][i]) begin
        req_i[i].valid        = (sent[0][i] < FlitsPerIn) && chance(50);
        req_i[i].flit         = ReqW'(rand_bits());
        req_i[i].flit.hdr.src = CoordW'(i);
        req_i[i].flit.hdr.tag = 8'(sent[0][i]);
        sent[0][i]           += int'(req_i[i].valid);
      end
      if (!rsp_i[i].valid || taken[1][i]) begin
        rsp_i[i].valid        = (sent[1][i] < FlitsPerIn) && chance(50);
        rsp_i[i].flit         = RspW'(rand_bits());
        rsp_i[i].flit.hdr.src = CoordW'(i);
        rsp_i[i].flit.hdr.tag = 8'(sent[1][i]);
        sent[1][i]           += int'(rsp_i[i].valid);
      end
      if (!wide_i[i].valid || taken[2][i]) begin
        wide_i[i].valid        = (sent[2][i] < FlitsPerIn) && chance(50);
        wide_i[i].flit         = WideW'(rand_bits());
        wide_i[i].flit.hdr.src = CoordW'(i);
        wide_i[i].flit.hdr.tag = 8'(sent[2][i]);
        sent[2][i]            += int'(wide_i[i].valid);
      end
      req_i[i].ready  = chance(70);
      rsp_i[i].ready  = chance(70);
      wide_i[i].ready = chance(70);
    end
  endtask

  function automatic bit all_sent();
    for (int i = 0; i < NumPorts; i++) begin
      if (sent[0][i] < FlitsPerIn || sent[1][i] < FlitsPerIn || sent[2][i] < FlitsPerIn) begin
        return 1'b0;
      end
      if ((req_i[i].valid && !taken[0][i]) || (rsp_i[i].valid && !taken[1][i]) ||
          (wide_i[i].valid && !taken[2][i])) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Called mid-cycle, so every handshake seen here completes at the next edge
  task automatic sample_cycle();
    int s;
    for (int i = 0; i < NumPorts; i++) begin
      if ((req_o_prev[i].valid && !req_i_prev[i].ready &&
           (!req_o[i].valid || req_o[i].flit !== req_o_prev[i].flit)) ||
          (rsp_o_prev[i].valid && !rsp_i_prev[i].ready &&
           (!rsp_o[i].valid || rsp_o[i].flit !== rsp_o_prev[i].flit)) ||
          (wide_o_prev[i].valid && !wide_i_prev[i].ready &&
           (!wide_o[i].valid || wide_o[i].flit !== wide_o_prev[i].flit))) begin
        report_failure($sformatf("Output port %0d dropped or changed a stalled flit", i));
      end
      taken[0][i] = req_i[i].valid && req_o[i].ready;
      taken[1][i] = rsp_i[i].valid && rsp_o[i].ready;
      taken[2][i] = wide_i[i].valid && wide_o[i].ready;
      if (taken[0][i]) begin
        req_q[i][xy_port(req_i[i].flit.hdr.dst, node_i)].push_back(req_i[i].flit);
      end
      if (taken[1][i]) begin
        rsp_q[i][xy_port(rsp_i[i].flit.hdr.dst, node_i)].push_back(rsp_i[i].flit);
      end
      if (taken[2][i]) begin
        wide_q[i][xy_port(wide_i[i].flit.hdr.dst, node_i)].push_back(wide_i[i].flit);
      end
      if (req_o[i].valid && req_i[i].ready) begin
        s = int'(req_o[i].flit.hdr.src);
        if (s >= NumPorts || req_q[s][i].size() == 0) begin
          report_failure($sformatf("Request output %0d sent a flit nobody expected", i));
        end else begin
          check_req("req_route", req_q[s][i].pop_front(), req_o[i].flit);
        end
      end
      if (rsp_o[i].valid && rsp_i[i].ready) begin
        s = int'(rsp_o[i].flit.hdr.src);
        if (s >= NumPorts || rsp_q[s][i].size() == 0) begin
          report_failure($sformatf("Response output %0d sent a flit nobody expected", i));
        end else begin
          check_rsp("rsp_payload", rsp_q[s][i].pop_front(), rsp_o[i].flit);
        end
      end
      if (wide_o[i].valid && wide_i[i].ready) begin
        s = int'(wide_o[i].flit.hdr.src);
        if (s >= NumPorts || wide_q[s][i].size() == 0) begin
          report_failure($sformatf("Wide output %0d sent a flit nobody expected", i));
        end else begin
          check_wide("wide_route", wide_q[s][i].pop_front(), wide_o[i].flit);
        end
      end
    end
    req_i_prev  = req_i;
    req_o_prev  = req_o;
    rsp_i_prev  = rsp_i;
    rsp_o_prev  = rsp_o;
    wide_i_prev = wide_i;
    wide_o_prev = wide_o;
  endtask

  initial begin
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    node_i.x    = `NOC_COORD_W'(1);
    node_i.y    = `NOC_COORD_W'(2);
    req_i       = '0;
    rsp_i       = '0;
    wide_i      = '0;
    req_o_prev  = '0;
    rsp_o_prev  = '0;
    wide_o_prev = '0;
    taken       = '0;
    repeat (2) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    @(negedge clk_i);
    for (int i = 0; i < NumPorts; i++) begin
      if ({req_o[i].valid, rsp_o[i].valid, wide_o[i].valid,
           req_o[i].ready, rsp_o[i].ready, wide_o[i].ready} !== 6'b000_111) begin
        report_failure($sformatf("Port %0d is not idle and ready right after reset", i));
      end
    end
    do begin
      @(posedge clk_i);
      #2;
      drive_inputs();
      @(negedge clk_i);
      sample_cycle();
    end while ((pending() != 0 || !all_sent()) && cycle_cnt < CycleLimit);
    if (pending() != 0 || !all_sent()) begin
      report_failure($sformatf("Run ended with %0d flits undelivered or stimulus not all sent",
                               pending()));
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
